// ==== list.f ====
+incdir+source
+incdir+verif
source/isaPkg.sv
source/ctrlPkg.sv
source/stageReg.sv
source/mainDecoder.sv
source/immGen.sv
source/ctrlAssembler.sv
source/decodeUnit.sv
verif/decodeUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module decodeUnitTb \
        -Mdir obj_dir -o decodeUnitSim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/decodeUnitSim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log
if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== verif/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected decode, built field by field from the ISA rules

function automatic logic [63:0] signExtend(input logic [63:0] v, input int bits);
    logic signed [63:0] t;
    t = v << (64 - bits);
    return t >>> (64 - bits);
endfunction

function automatic logic [`XLEN-1:0] expectedImm(input logic [`ILEN-1:0] i);
    case (i[6:0])
        opLoad, opOpImm, opOpImm32, opJalr: return signExtend(64'(i[31:20]), 12);
        opStore: return signExtend(64'({i[31:25], i[11:7]}), 12);
        opBranch: return signExtend(64'({i[31], i[7], i[30:25], i[11:8], 1'b0}), 13);
        opLui, opAuipc: return signExtend(64'({i[31:12], 12'h000}), 32);
        opJal: return signExtend(64'({i[31], i[19:12], i[20], i[30:21], 1'b0}), 21);
        default: return '0;
    endcase
endfunction

function automatic memSizeT sizeMask(input logic [1:0] sz);
    case (sz)
        2'd0:    return sizeByte;
        2'd1:    return sizeHalf;
        2'd2:    return sizeWord;
        default: return sizeDouble;
    endcase
endfunction

// subOk is only set for register ops, there is no SUBI
function automatic aluCtrlT expectedAluCtrl(input logic [2:0] f3, input logic subOk,
                                            input logic alt);
    case (f3)
        3'b000:  return (subOk && alt) ? aluSub : aluAdd;
        3'b001:  return aluSll;
        3'b010:  return aluSlt;
        3'b011:  return aluSltu;
        3'b100:  return aluXor;
        3'b101:  return alt ? aluSra : aluSrl;
        3'b110:  return aluOr;
        default: return aluAnd;
    endcase
endfunction

function automatic decodedBundleT expectedBundle(input logic [`ILEN-1:0] i, input privT p);
    decodedBundleT b;
    logic [2:0] f3;
    b = '0;
    f3 = i[14:12];
    b.imm = expectedImm(i);
    b.rs1 = i[19:15];
    b.rs2 = i[24:20];
    b.rd = i[11:7];
    case (i[6:0])
        opLoad: begin
            b.aluSrc = 1'b1;
            b.memToReg = 1'b1;
            b.memSize = sizeMask(f3[1:0]);
            if (f3 == 3'b111) begin
                b.except = excIllegal;
            end else begin
                b.regWrite = 1'b1;
                b.memRead = f3[2] ? memUnsigned : memSigned;
            end
        end
        opStore: begin
            b.aluSrc = 1'b1;
            b.memSize = sizeMask(f3[1:0]);
            if (f3[2]) begin
                b.except = excIllegal;
            end else begin
                b.memWrite = 1'b1;
            end
        end
        opBranch: begin
            b.aluOp = aluOpBranch;
            b.aluCtrl = aluSub;
            case (f3)
                3'b000:  b.branchCond = brEq;
                3'b001:  b.branchCond = brNe;
                3'b100:  b.branchCond = brLt;
                3'b101:  b.branchCond = brGe;
                3'b110:  b.branchCond = brLtu;
                3'b111:  b.branchCond = brGeu;
                default: b.except = excIllegal;
            endcase
        end
        opOp, opOp32: begin
            b.regWrite = 1'b1;
            b.aluOp = aluOpReg;
            b.wordOp = (i[6:0] == opOp32);
            b.aluCtrl = expectedAluCtrl(f3, 1'b1, i[30]);
        end
        opOpImm, opOpImm32: begin
            b.aluSrc = 1'b1;
            b.regWrite = 1'b1;
            b.aluOp = aluOpImm;
            b.wordOp = (i[6:0] == opOpImm32);
            b.aluCtrl = expectedAluCtrl(f3, 1'b0, i[30]);
        end
        opLui, opAuipc: begin
            b.aluSrc = 1'b1;
            b.regWrite = 1'b1;
            b.regSel = (i[6:0] == opLui) ? selImm : selPcImm;
            b.aluCtrl = (i[6:0] == opLui) ? aluPassB : aluAdd;
        end
        opJal, opJalr: begin
            b.regSel = selPc4;
            b.branchCond = brAlways;
            b.aluOp = aluOpBranch;
            b.aluCtrl = aluSub;
            if (i[6:0] == opJalr && f3 != 3'b000) begin
                b.except = excIllegal;
            end else begin
                b.regWrite = 1'b1;
            end
        end
        opSystem: begin
            if (f3 == 3'b000 && i[31:20] == 12'h001) begin
                b.except = excBreakpoint;
            end else if (f3 == 3'b000 && i[31:20] == 12'h000) begin
                b.except = (p == privU) ? excEcallU : (p == privS) ? excEcallS : excEcallM;
            end else begin
                b.except = excIllegal;
            end
        end
        default: b.except = excIllegal;
    endcase
    return b;
endfunction

// one instruction of class cls, fields from r, rare illegal variants picked by s
function automatic logic [`ILEN-1:0] makeInstr(input int cls, input logic [31:0] r,
                                               input logic [31:0] s);
    logic [2:0] f3;
    case (cls)
        0: return {r[31:7], opLoad};
        1: begin
            f3 = (s[3:0] == 4'h0) ? r[14:12] : {1'b0, r[13:12]};
            return {r[31:15], f3, r[11:7], opStore};
        end
        2: return {r[31:7], opBranch};
        3: return {1'b0, r[30], 5'b0, r[24:7], opOp};
        4: return {1'b0, r[30], 5'b0, r[24:7], opOp32};
        5: return {r[31:7], opOpImm};
        6: return {r[31:7], opOpImm32};
        7: return {r[31:7], opLui};
        8: return {r[31:7], opAuipc};
        9: return {r[31:7], opJal};
        10: begin
            f3 = (s[3:0] == 4'h0) ? r[14:12] : 3'b000;
            return {r[31:15], f3, r[11:7], opJalr};
        end
        11: begin
            // half ecall, then ebreak, then csr space
            if (!s[5]) begin
                return {25'h0, opSystem};
            end else if (!s[4]) begin
                return {12'h001, 13'h0, opSystem};
            end else begin
                return {r[31:7], opSystem};
            end
        end
        default: return {r[31:7], s[6:0]};
    endcase
endfunction

`endif

// ==== verif/decodeUnitTb.sv ====
`timescale 1ns/1ps
`include "rv64_settings.svh"

module decodeUnitTb
    import isaPkg::*, ctrlPkg::*;
();

    localparam int numRandom = 400;
    localparam int numStream = 200;
    // worst case cycles per item under gaps and stalls
    localparam int stallFactor = 8;
    localparam int timeoutNs = (numRandom + numStream) * 8 * stallFactor + 2000;

    logic             clk = 1'b0;
    logic             rstN;
    logic             instValid;
    logic             instReady;
    logic [`ILEN-1:0] instr;
    privT             priv;
    logic             decValid;
    logic             decReady;
    excCauseT         except;
    logic             wordOp;
    regSelT           regSel;
    logic             aluSrc;
    logic             memToReg;
    logic             regWrite;
    memReadT          memRead;
    logic             memWrite;
    memSizeT          memSize;
    branchCondT       branchCond;
    aluOpT            aluOp;
    aluCtrlT          aluCtrl;
    logic [`XLEN-1:0] imm;
    logic [`REGW-1:0] rs1;
    logic [`REGW-1:0] rs2;
    logic [`REGW-1:0] rd;

    integer        seed;
    int            cycle;
    int            extraCount;
    decodedBundleT expQ[$];
    int            acceptQ[$];

    `include "decodeModel.svh"

    decodeUnit decodeUnit_i (.*);

    always #4 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic reportError(input string msg);
        abortRun($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    task automatic checkExcept(input excCauseT got, input excCauseT exp);
        if (got !== exp) begin
            reportError($sformatf("except got %0d expected %0d", got, exp));
        end
    endtask

    task automatic checkImm(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            reportError($sformatf("imm got %h expected %h", got, exp));
        end
    endtask

    task automatic checkRegIdx(input string name, input logic [`REGW-1:0] got,
                               input logic [`REGW-1:0] exp);
        if (got !== exp) begin
            reportError($sformatf("%s got %0d expected %0d", name, got, exp));
        end
    endtask

    task automatic checkCtrl(input decodedBundleT got, input decodedBundleT exp);
        if (got.wordOp !== exp.wordOp)
            reportError($sformatf("wordOp got %0b expected %0b", got.wordOp, exp.wordOp));
        if (got.regSel !== exp.regSel)
            reportError($sformatf("regSel got %0d expected %0d", got.regSel, exp.regSel));
        if (got.aluSrc !== exp.aluSrc)
            reportError($sformatf("aluSrc got %0b expected %0b", got.aluSrc, exp.aluSrc));
        if (got.memToReg !== exp.memToReg)
            reportError($sformatf("memToReg got %0b expected %0b", got.memToReg, exp.memToReg));
        if (got.regWrite !== exp.regWrite)
            reportError($sformatf("regWrite got %0b expected %0b", got.regWrite, exp.regWrite));
        if (got.memRead !== exp.memRead)
            reportError($sformatf("memRead got %0d expected %0d", got.memRead, exp.memRead));
        if (got.memWrite !== exp.memWrite)
            reportError($sformatf("memWrite got %0b expected %0b", got.memWrite, exp.memWrite));
        if (got.memSize !== exp.memSize)
            reportError($sformatf("memSize got %0d expected %0d", got.memSize, exp.memSize));
        if (got.branchCond !== exp.branchCond)
            reportError($sformatf("branchCond got %0d expected %0d", got.branchCond,
                                  exp.branchCond));
        if (got.aluOp !== exp.aluOp)
            reportError($sformatf("aluOp got %0d expected %0d", got.aluOp, exp.aluOp));
        if (got.aluCtrl !== exp.aluCtrl)
            reportError($sformatf("aluCtrl got %0d expected %0d", got.aluCtrl, exp.aluCtrl));
    endtask

    task automatic popAndCompare(input bit timed);
        decodedBundleT expB;
        decodedBundleT gotB;
        int accepted;
        if (expQ.size() == 0) begin
            abortRun("DUT delivered a result with no instruction pending");
        end else begin
            expB = expQ.pop_front();
            accepted = acceptQ.pop_front();
            gotB = '{except: except, wordOp: wordOp, regSel: regSel, aluSrc: aluSrc,
                     memToReg: memToReg, regWrite: regWrite, memRead: memRead,
                     memWrite: memWrite, memSize: memSize, branchCond: branchCond,
                     aluOp: aluOp, aluCtrl: aluCtrl, imm: imm, rs1: rs1, rs2: rs2, rd: rd};
            checkExcept(except, expB.except);
            checkCtrl(gotB, expB);
            checkImm(imm, expB.imm);
            checkRegIdx("rs1", rs1, expB.rs1);
            checkRegIdx("rs2", rs2, expB.rs2);
            checkRegIdx("rd", rd, expB.rd);
            // accept edge to output transfer edge
            if (timed && cycle - accepted != 2) begin
                reportError($sformatf("latency got %0d cycles expected 2", cycle - accepted));
            end
        end
    endtask

    // stream mode keeps instValid and decReady high the whole phase
    task automatic runPhase(input int count, input bit stream);
        int sent;
        int cls;
        bit inFired;
        logic [31:0] r;
        logic [31:0] s;
        sent = 0;
        inFired = 1'b0;
        while (sent < count || expQ.size() != 0) begin
            @(negedge clk);
            if (inFired) begin
                instValid = 1'b0;
            end
            inFired = 1'b0;
            if (!instValid && sent < count && (stream || {$random(seed)} % 4 != 0)) begin
                r = $random(seed);
                s = $random(seed);
                cls = {$random(seed)} % 13;
                instr = makeInstr(cls, r, s);
                priv = (s[9:8] == 2'b00) ? privU : (s[9:8] == 2'b01) ? privS : privM;
                instValid = 1'b1;
            end
            decReady = stream || ({$random(seed)} % 4 != 0);
            // handshake settles well before the rising edge
            #1;
            if (instValid && instReady) begin
                expQ.push_back(expectedBundle(instr, priv));
                acceptQ.push_back(cycle);
                sent++;
                inFired = 1'b1;
            end
            if (decValid && decReady) begin
                popAndCompare(stream);
            end
            cycle++;
        end
    endtask

    initial begin
        #(timeoutNs);
        abortRun($sformatf("run hung without finishing after %0d ns", timeoutNs));
    end

    initial begin
        seed = 32'hbe2ef9b7;
        cycle = 0;
        extraCount = 0;
        rstN = 1'b0;
        instValid = 1'b0;
        instr = '0;
        priv = privU;
        decReady = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        #1;
        if (decValid !== 1'b0 || instReady !== 1'b1) begin
            abortRun("handshake was not idle after reset");
        end
        runPhase(numRandom, 1'b0);
        runPhase(numStream, 1'b1);
        // both stages are drained, nothing more may come out
        repeat (4) begin
            @(negedge clk);
            decReady = 1'b1;
            #1;
            if (decValid !== 1'b0) begin
                extraCount++;
            end
        end
        if (extraCount != 0) begin
            abortRun($sformatf("%0d results seen after the last instruction", extraCount));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== source/decodeUnit.sv ====
`timescale 1ns/1ps
`include "rv64_settings.svh"

module decodeUnit
    import isaPkg::*, ctrlPkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             instValid,
    output logic             instReady,
    input  logic [`ILEN-1:0] instr,
    input  privT             priv,
    output logic             decValid,
    input  logic             decReady,
    output excCauseT         except,
    output logic             wordOp,
    output regSelT           regSel,
    output logic             aluSrc,
    output logic             memToReg,
    output logic             regWrite,
    output memReadT          memRead,
    output logic             memWrite,
    output memSizeT          memSize,
    output branchCondT       branchCond,
    output aluOpT            aluOp,
    output aluCtrlT          aluCtrl,
    output logic [`XLEN-1:0] imm,
    output logic [`REGW-1:0] rs1,
    output logic [`REGW-1:0] rs2,
    output logic [`REGW-1:0] rd
);

    fetchBundleT      fetchIn;
    fetchBundleT      fetchQ;
    logic             fetchValid;
    logic             fetchReady;
    decodedBundleT    decNext;
    decodedBundleT    decQ;
    excCauseT         rawExcept;
    regSelT           rawRegSel;
    memReadT          rawMemRead;
    memSizeT          rawMemSize;
    branchCondT       rawBranchCond;
    aluOpT            rawAluOp;
    logic             rawWordOp;
    logic             rawAluSrc;
    logic             rawMemToReg;
    logic             rawRegWrite;
    logic             rawMemWrite;
    logic [`XLEN-1:0] rawImm;

    assign fetchIn = '{instr: instr, priv: priv};

    stageReg #(.payloadT(fetchBundleT)) fetchStage_i (
        .clk(clk), .rstN(rstN),
        .inValid(instValid), .inReady(instReady), .inData(fetchIn),
        .outValid(fetchValid), .outReady(fetchReady), .outData(fetchQ)
    );

    mainDecoder mainDecoder_i (
        .instr(fetchQ.instr), .priv(fetchQ.priv), .except(rawExcept),
        .wordOp(rawWordOp), .regSel(rawRegSel), .aluSrc(rawAluSrc),
        .memToReg(rawMemToReg), .regWrite(rawRegWrite), .memRead(rawMemRead),
        .memWrite(rawMemWrite), .memSize(rawMemSize), .branchCond(rawBranchCond),
        .aluOp(rawAluOp)
    );

    immGen immGen_i (.instr(fetchQ.instr), .imm(rawImm));

    ctrlAssembler ctrlAssembler_i (
        .instr(fetchQ.instr), .except(rawExcept), .wordOp(rawWordOp),
        .regSel(rawRegSel), .aluSrc(rawAluSrc), .memToReg(rawMemToReg),
        .regWrite(rawRegWrite), .memRead(rawMemRead), .memWrite(rawMemWrite),
        .memSize(rawMemSize), .branchCond(rawBranchCond), .aluOp(rawAluOp),
        .imm(rawImm), .bundle(decNext)
    );

    stageReg #(.payloadT(decodedBundleT)) decodeStage_i (
        .clk(clk), .rstN(rstN),
        .inValid(fetchValid), .inReady(fetchReady), .inData(decNext),
        .outValid(decValid), .outReady(decReady), .outData(decQ)
    );

    // registered bundle out to loose ports
    assign except = decQ.except;
    assign wordOp = decQ.wordOp;
    assign regSel = decQ.regSel;
    assign aluSrc = decQ.aluSrc;
    assign memToReg = decQ.memToReg;
    assign regWrite = decQ.regWrite;
    assign memRead = decQ.memRead;
    assign memWrite = decQ.memWrite;
    assign memSize = decQ.memSize;
    assign branchCond = decQ.branchCond;
    assign aluOp = decQ.aluOp;
    assign aluCtrl = decQ.aluCtrl;
    assign imm = decQ.imm;
    assign rs1 = decQ.rs1;
    assign rs2 = decQ.rs2;
    assign rd = decQ.rd;

endmodule

// ==== source/ctrlAssembler.sv ====
`timescale 1ns/1ps
`include "rv64_settings.svh"

module ctrlAssembler
    import isaPkg::*, ctrlPkg::*;
(
    input  logic [`ILEN-1:0] instr,
    input  excCauseT         except,
    input  logic             wordOp,
    input  regSelT           regSel,
    input  logic             aluSrc,
    input  logic             memToReg,
    input  logic             regWrite,
    input  memReadT          memRead,
    input  logic             memWrite,
    input  memSizeT          memSize,
    input  branchCondT       branchCond,
    input  aluOpT            aluOp,
    input  logic [`XLEN-1:0] imm,
    output decodedBundleT    bundle
);

    logic [2:0] funct3;
    logic       altOp;
    logic       faulted;
    aluCtrlT    aluCtrl;

    assign funct3 = instr[14:12];
    // funct7[5], also bit 10 of the shift-immediate field
    assign altOp = instr[30];
    assign faulted = (except != excNone);

    always_comb begin
        case (aluOp)
            aluOpAdd:    aluCtrl = (regSel == selImm) ? aluPassB : aluAdd;
            aluOpBranch: aluCtrl = aluSub;
            aluOpReg: begin
                aluCtrl = aluCtrlT'({altOp && (funct3 == f3AddSub || funct3 == f3SrlSra),
                                     funct3});
            end
            default: aluCtrl = aluCtrlT'({altOp && funct3 == f3SrlSra, funct3});
        endcase
        // loads and stores are the only memory users and neither pairs with the other
        assert (!(regWrite === 1'b1 && memWrite === 1'b1));
    end

    always_comb begin
        bundle.except = except;
        bundle.wordOp = wordOp;
        bundle.regSel = regSel;
        bundle.aluSrc = aluSrc;
        bundle.memToReg = memToReg;
        // a trapping instruction must leave no architectural trace
        bundle.regWrite = regWrite && !faulted;
        bundle.memRead = faulted ? memNone : memRead;
        bundle.memWrite = memWrite && !faulted;
        bundle.memSize = memSize;
        bundle.branchCond = branchCond;
        bundle.aluOp = aluOp;
        bundle.aluCtrl = aluCtrl;
        bundle.imm = imm;
        bundle.rs1 = instr[19:15];
        bundle.rs2 = instr[24:20];
        bundle.rd = instr[11:7];
    end

endmodule

// ==== source/immGen.sv ====
`timescale 1ns/1ps
`include "rv64_settings.svh"

module immGen
    import isaPkg::*;
(
    input  logic [`ILEN-1:0] instr,
    output logic [`XLEN-1:0] imm
);

    logic [6:0] opcode;
    logic       signBit;
    instFmtT    fmt;

    assign opcode = instr[6:0];
    // all formats keep the sign in bit 31
    assign signBit = instr[31];

    always_comb begin
        case (opcode)
            opLoad, opOpImm, opOpImm32, opJalr: fmt = fmtI;
            opStore:                            fmt = fmtS;
            opBranch:                           fmt = fmtB;
            opLui, opAuipc:                     fmt = fmtU;
            opJal:                              fmt = fmtJ;
            default:                            fmt = fmtR;
        endcase
    end

    always_comb begin
        case (fmt)
            fmtI: imm = {{(`XLEN-12){signBit}}, instr[31:20]};
            fmtS: imm = {{(`XLEN-12){signBit}}, instr[31:25], instr[11:7]};
            fmtB: begin
                imm = {{(`XLEN-13){signBit}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            fmtU: imm = {{(`XLEN-32){signBit}}, instr[31:12], 12'b0};
            fmtJ: begin
                imm = {{(`XLEN-21){signBit}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== source/mainDecoder.sv ====
`timescale 1ns/1ps
`include "rv64_settings.svh"

module mainDecoder
    import isaPkg::*, ctrlPkg::*;
(
    input  logic [`ILEN-1:0] instr,
    input  privT             priv,
    output excCauseT         except,
    output logic             wordOp,
    output regSelT           regSel,
    output logic             aluSrc,
    output logic             memToReg,
    output logic             regWrite,
    output memReadT          memRead,
    output logic             memWrite,
    output memSizeT          memSize,
    output branchCondT       branchCond,
    output aluOpT            aluOp
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct12 = instr[31:20];

    // low two funct3 bits give the access width for loads and stores
    function automatic memSizeT sizeFromF3(input logic [1:0] sz);
        case (sz)
            2'b00:   return sizeByte;
            2'b01:   return sizeHalf;
            2'b10:   return sizeWord;
            default: return sizeDouble;
        endcase
    endfunction

    always_comb begin
        except = excNone;
        wordOp = 1'b0;
        regSel = selNormal;
        aluSrc = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        memRead = memNone;
        memWrite = 1'b0;
        memSize = sizeByte;
        branchCond = brNone;
        aluOp = aluOpAdd;
        case (opcode)
            opBranch: begin
                aluOp = aluOpBranch;
                case (funct3)
                    f3Beq:   branchCond = brEq;
                    f3Bne:   branchCond = brNe;
                    f3Blt:   branchCond = brLt;
                    f3Bge:   branchCond = brGe;
                    f3Bltu:  branchCond = brLtu;
                    f3Bgeu:  branchCond = brGeu;
                    default: except = excIllegal;
                endcase
            end
            opOp, opOp32: begin
                regWrite = 1'b1;
                aluOp = aluOpReg;
                wordOp = (opcode == opOp32);
            end
            opOpImm, opOpImm32: begin
                aluSrc = 1'b1;
                regWrite = 1'b1;
                aluOp = aluOpImm;
                wordOp = (opcode == opOpImm32);
            end
            opLoad: begin
                aluSrc = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                memRead = funct3[2] ? memUnsigned : memSigned;
                memSize = sizeFromF3(funct3[1:0]);
                if (funct3 == f3LoadRsvd) begin
                    except = excIllegal;
                end
            end
            opStore: begin
                aluSrc = 1'b1;
                memWrite = 1'b1;
                memSize = sizeFromF3(funct3[1:0]);
                // no store wider than a doubleword
                if (funct3[2]) begin
                    except = excIllegal;
                end
            end
            opLui, opAuipc: begin
                aluSrc = 1'b1;
                regWrite = 1'b1;
                regSel = (opcode == opLui) ? selImm : selPcImm;
            end
            opJal, opJalr: begin
                regWrite = 1'b1;
                regSel = selPc4;
                branchCond = brAlways;
                aluOp = aluOpBranch;
                if (opcode == opJalr && funct3 != f3Zero) begin
                    except = excIllegal;
                end
            end
            opSystem: begin
                // csr ops, mret, sret and wfi all land on illegal
                except = excIllegal;
                if (funct3 == f3Zero && funct12 == f12Ebreak) begin
                    except = excBreakpoint;
                end else if (funct3 == f3Zero && funct12 == f12Ecall) begin
                    case (priv)
                        privU:   except = excEcallU;
                        privS:   except = excEcallS;
                        privM:   except = excEcallM;
                        default: except = excIllegal;
                    endcase
                end
            end
            default: except = excIllegal;
        endcase
    end

endmodule

// ==== source/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    fullQ;
    payloadT dataQ;

    // take a new item when empty or when the held one leaves this edge
    assign inReady = !fullQ || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fullQ <= 1'b0;
        end else if (inReady) begin
            fullQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            dataQ <= inData;
        end
    end

    assign outValid = fullQ;
    assign outData = dataQ;

    // a stalled item must not change under the consumer
    holdStable: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outData));

    emptyAfterReset: assert property (@(posedge clk) !rstN |=> !outValid);

endmodule

// ==== source/ctrlPkg.sv ====
`include "rv64_settings.svh"

package ctrlPkg;

    typedef enum logic [2:0] {
        excNone       = 3'b000,
        excBreakpoint = 3'b001,
        excEcallU     = 3'b010,
        excEcallS     = 3'b011,
        excIllegal    = 3'b100,
        excEcallM     = 3'b101
    } excCauseT;

    // source of the register write-back value
    typedef enum logic [1:0] {
        selNormal = 2'b00,
        selImm    = 2'b01,
        selPcImm  = 2'b10,
        selPc4    = 2'b11
    } regSelT;

    typedef enum logic [1:0] {
        memNone     = 2'b00,
        memUnsigned = 2'b01,
        memSigned   = 2'b11
    } memReadT;

    // byte lane mask, upper bits fill in as the access widens
    typedef enum logic [2:0] {
        sizeByte   = 3'b000,
        sizeHalf   = 3'b001,
        sizeWord   = 3'b011,
        sizeDouble = 3'b111
    } memSizeT;

    typedef enum logic [2:0] {
        brNone   = 3'b000,
        brEq     = 3'b001,
        brGeu    = 3'b010,
        brNe     = 3'b011,
        brGe     = 3'b100,
        brLt     = 3'b101,
        brLtu    = 3'b110,
        brAlways = 3'b111
    } branchCondT;

    typedef enum logic [1:0] {
        aluOpAdd    = 2'b00,
        aluOpBranch = 2'b01,
        aluOpReg    = 2'b10,
        aluOpImm    = 2'b11
    } aluOpT;

    // encoded as {funct7[5], funct3} so decode can build it directly
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSll   = 4'b0001,
        aluSlt   = 4'b0010,
        aluSltu  = 4'b0011,
        aluXor   = 4'b0100,
        aluSrl   = 4'b0101,
        aluOr    = 4'b0110,
        aluAnd   = 4'b0111,
        aluSub   = 4'b1000,
        aluSra   = 4'b1101,
        aluPassB = 4'b1111
    } aluCtrlT;

    typedef struct packed {
        excCauseT except;
        logic wordOp;
        regSelT regSel;
        logic aluSrc;
        logic memToReg;
        logic regWrite;
        memReadT memRead;
        logic memWrite;
        memSizeT memSize;
        branchCondT branchCond;
        aluOpT aluOp;
        aluCtrlT aluCtrl;
        logic [`XLEN-1:0] imm;
        logic [`REGW-1:0] rs1;
        logic [`REGW-1:0] rs2;
        logic [`REGW-1:0] rd;
    } decodedBundleT;

endpackage

// ==== source/isaPkg.sv ====
`include "rv64_settings.svh"

package isaPkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad    = 7'b0000011,
        opStore   = 7'b0100011,
        opBranch  = 7'b1100011,
        opOp      = 7'b0110011,
        opOp32    = 7'b0111011,
        opOpImm   = 7'b0010011,
        opOpImm32 = 7'b0011011,
        opLui     = 7'b0110111,
        opAuipc   = 7'b0010111,
        opJal     = 7'b1101111,
        opJalr    = 7'b1100111,
        opSystem  = 7'b1110011
    } opcodeT;

    typedef enum logic [1:0] {
        privU = 2'b00,
        privS = 2'b01,
        privM = 2'b11
    } privT;

    // immediate layouts, R has none
    typedef enum logic [2:0] {fmtR, fmtI, fmtS, fmtB, fmtU, fmtJ} instFmtT;

    // branch conditions
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // would be an unsigned doubleword load, not in RV64I
    localparam logic [2:0] f3LoadRsvd = 3'b111;

    // ops whose funct7[5] selects the alternate form
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3SrlSra = 3'b101;

    // jalr and the privileged group both require zero
    localparam logic [2:0] f3Zero = 3'b000;

    localparam logic [11:0] f12Ecall = 12'h000;
    localparam logic [11:0] f12Ebreak = 12'h001;

    typedef struct packed {
        logic [`ILEN-1:0] instr;
        privT priv;
    } fetchBundleT;

endpackage

// ==== source/rv64_settings.svh ====
`ifndef RV64_SETTINGS_SVH
`define RV64_SETTINGS_SVH

// integer register and immediate width
`define XLEN 64

// uncompressed instruction word
`define ILEN 32

// architectural register index
`define REGW 5

`endif
